// File: source/pipe_cfg.svh
`ifndef PIPE_CFG_SVH
`define PIPE_CFG_SVH

// Instruction word layout
`define PIPE_IW        32
`define PIPE_OP_HI     31
`define PIPE_OP_LO     27
`define PIPE_RD_HI     26
`define PIPE_RD_LO     22
`define PIPE_RS1_HI    21
`define PIPE_RS1_LO    17
`define PIPE_IMM_BIT   16
`define PIPE_RS2_HI    15
`define PIPE_RS2_LO    11
`define PIPE_NOP_WORD  {`PIPE_IW{1'b0}}

`endif

// File: source/pipe_pkg.sv
`include "pipe_cfg.svh"

package pipe_pkg;

	// Opcode encodings, codes above op_hlt are undefined
	typedef enum logic [4:0] {
		op_noop = 5'd0,
		op_add,
		op_sub,
		op_or,
		op_and,
		op_not,
		op_xor,
		op_cmp,
		op_br,
		op_jmp,
		op_ld,
		op_ldi,
		op_ldx,
		op_st,
		op_stx,
		op_hlt  = 5'd15
	} opcode_t;

	// Decoded instruction class flags
	typedef struct packed {
		logic add;
		logic sub;
		logic cmp;
		logic br;
		logic jmp;
		logic ld;
		logic ldi;
		logic ldx;
		logic st;
		logic stx;
		logic hlt;
		// add through cmp
		logic alu;
		// ALU ops that write a register
		logic alu_wr;
		// Condition code writers
		logic cc_wr;
	} op_class_t;

	typedef logic [`PIPE_IW-1:0] instr_t;

endpackage

// File: source/stage_if.sv
`timescale 1ns/100ps

interface stage_if (
	input logic clk,
	input logic arst_n
);
	import pipe_pkg::*;

	// Stage words from the instruction pipe
	instr_t ir2;
	instr_t ir3;
	instr_t ir4;
	instr_t ir5;

	// Pipe control levels from the hazard unit
	logic   pause2;
	logic   pause3;
	logic   nop2;

	modport pipe (output ir2, ir3, ir4, ir5, input pause2, pause3, nop2);
	modport hz (input clk, arst_n, ir2, ir3, ir4, ir5, output pause2, pause3, nop2);

endinterface

// File: source/opdec.sv
`timescale 1ns/100ps

module opdec (
	input  pipe_pkg::opcode_t   op,
	output pipe_pkg::op_class_t cls
);
	import pipe_pkg::*;

	always_comb begin
		cls = '0;
		case (op)
			op_add: begin
				cls.add    = 1'b1;
				cls.alu    = 1'b1;
				cls.alu_wr = 1'b1;
				cls.cc_wr  = 1'b1;
			end
			op_sub: begin
				cls.sub    = 1'b1;
				cls.alu    = 1'b1;
				cls.alu_wr = 1'b1;
				cls.cc_wr  = 1'b1;
			end
			op_or, op_and, op_not, op_xor: begin
				cls.alu    = 1'b1;
				cls.alu_wr = 1'b1;
			end
			// Compare only sets the condition code
			op_cmp: begin
				cls.cmp   = 1'b1;
				cls.alu   = 1'b1;
				cls.cc_wr = 1'b1;
			end
			op_br:   cls.br  = 1'b1;
			op_jmp:  cls.jmp = 1'b1;
			op_ld:   cls.ld  = 1'b1;
			op_ldi:  cls.ldi = 1'b1;
			op_ldx:  cls.ldx = 1'b1;
			op_st:   cls.st  = 1'b1;
			op_stx:  cls.stx = 1'b1;
			op_hlt:  cls.hlt = 1'b1;
			// noop and undefined codes have no class
			default: cls = '0;
		endcase
	end

endmodule

// File: source/hazard.sv
`timescale 1ns/100ps

`include "pipe_cfg.svh"

module hazard (
	input  logic cond2,
	input  logic cond3,
	input  logic cond4,
	stage_if.hz  stg,
	output logic fetch_stall,
	output logic alux_z4_sel,
	output logic alux_pc4_sel,
	output logic alux_z5_sel,
	output logic aluy_z4_sel,
	output logic aluy_pc4_sel,
	output logic aluy_z5_sel,
	output logic md4_z4_sel,
	output logic md4_pc4_sel,
	output logic md4_z5_sel,
	output logic rf_fwd_rs1,
	output logic rf_fwd_rs2,
	output logic rf_fwd_rd,
	output logic mem_fwd_st
);
	import pipe_pkg::*;

	op_class_t  c2, c3, c4, c5;
	logic [4:0] d2, d3, d4, d5;
	logic [4:0] s12, s22, s13, s23;
	logic       imm2, imm3, imm4, imm5;
	logic       wb4, jl4, wb5;
	logic       use1, use1p, use2, st_any3;
	logic       ld_any3, ld_any4, corner;
	logic       pause2, pause3, nop2;

	opdec u_dec2 (.op(opcode_t'(stg.ir2[`PIPE_OP_HI:`PIPE_OP_LO])), .cls(c2));
	opdec u_dec3 (.op(opcode_t'(stg.ir3[`PIPE_OP_HI:`PIPE_OP_LO])), .cls(c3));
	opdec u_dec4 (.op(opcode_t'(stg.ir4[`PIPE_OP_HI:`PIPE_OP_LO])), .cls(c4));
	opdec u_dec5 (.op(opcode_t'(stg.ir5[`PIPE_OP_HI:`PIPE_OP_LO])), .cls(c5));

	// Register fields of each stage
	assign d2   = stg.ir2[`PIPE_RD_HI:`PIPE_RD_LO];
	assign d3   = stg.ir3[`PIPE_RD_HI:`PIPE_RD_LO];
	assign d4   = stg.ir4[`PIPE_RD_HI:`PIPE_RD_LO];
	assign d5   = stg.ir5[`PIPE_RD_HI:`PIPE_RD_LO];
	assign s12  = stg.ir2[`PIPE_RS1_HI:`PIPE_RS1_LO];
	assign s22  = stg.ir2[`PIPE_RS2_HI:`PIPE_RS2_LO];
	assign s13  = stg.ir3[`PIPE_RS1_HI:`PIPE_RS1_LO];
	assign s23  = stg.ir3[`PIPE_RS2_HI:`PIPE_RS2_LO];
	assign imm2 = stg.ir2[`PIPE_IMM_BIT];
	assign imm3 = stg.ir3[`PIPE_IMM_BIT];
	assign imm4 = stg.ir4[`PIPE_IMM_BIT];
	assign imm5 = stg.ir5[`PIPE_IMM_BIT];

	// Result producers in stages 4 and 5
	assign wb4 = c4.alu_wr | c4.ldi;
	assign jl4 = c4.jmp & imm4;
	assign wb5 = c5.alu_wr | c5.ld | c5.ldx | c5.ldi | (c5.jmp & imm5);

	// Operand consumers in stage 3
	assign use1    = c3.alu | c3.ldx | c3.stx | c3.jmp;
	assign use1p   = c3.alu | c3.ldx | c3.stx | (c3.jmp & imm3);
	assign use2    = c3.alu & ~imm3;
	assign st_any3 = c3.st | c3.stx;

	assign ld_any3 = c3.ld | c3.ldx | c3.ldi;
	assign ld_any4 = c4.ld | c4.ldx | c4.ldi;

	// Load-use, the loaded value is not ready until stage 5
	assign pause3 = (c4.ld | c4.ldx)
		& (((d4 == s13) & use1p) | (use2 & (d4 == s23)));

	// ALU op in stage 2 needing both loads at once
	assign corner = c2.alu & ld_any3 & ld_any4
		& (((d3 == s12) & (d4 == s22)) | ((d3 == s22) & (d4 == s12)));

	assign pause2 = pause3 | (c2.br & c3.cc_wr) | corner;

	// Squash the fetched word on control flow changes
	assign nop2 = c2.jmp | c3.jmp | c4.jmp
		| c2.hlt | c3.hlt | c4.hlt | c5.hlt
		| (cond2 & ~c3.cc_wr)
		| (c3.br & cond3)
		| (c4.br & cond4);

	assign stg.pause2 = pause2;
	assign stg.pause3 = pause3;
	assign stg.nop2   = nop2;
	assign fetch_stall = pause2;

	// Execute X operand
	assign alux_z4_sel  = (d4 == s13) & use1 & wb4;
	assign alux_pc4_sel = (d4 == s13) & use1 & jl4;
	assign alux_z5_sel  = (d5 == s13) & use1 & wb5;

	// Execute Y operand, register form only
	assign aluy_z4_sel  = (d4 == s23) & use2 & wb4;
	assign aluy_pc4_sel = (d4 == s23) & use2 & jl4;
	assign aluy_z5_sel  = (d5 == s23) & use2 & wb5;

	// Store data
	assign md4_z4_sel  = st_any3 & (d4 == d3) & wb4;
	assign md4_pc4_sel = st_any3 & (d4 == d3) & jl4;
	assign md4_z5_sel  = st_any3 & (d5 == d3) & wb5;

	// Bypass around the register file read in stage 2
	assign rf_fwd_rs1 = (d5 == s12) & (c2.alu | c2.ldx | c2.stx) & wb5;
	assign rf_fwd_rs2 = (d5 == s22) & c2.alu & ~imm2 & wb5;
	assign rf_fwd_rd  = (d5 == d2) & (c2.st | c2.stx) & wb5;

	// Load directly followed by a store of the same register
	assign mem_fwd_st = (d5 == d4) & (c5.ld | c5.ldx) & (c4.st | c4.stx);

	// Bubble in stage 4 ends a load-use stall after one cycle
	a_pause3_one_cycle: assert property (
		@(posedge stg.clk) disable iff (!stg.arst_n) pause3 |=> !pause3
	);

	a_outputs_known: assert property (
		@(posedge stg.clk) disable iff (!stg.arst_n)
		!$isunknown({fetch_stall, alux_z4_sel, alux_pc4_sel, alux_z5_sel,
			aluy_z4_sel, aluy_pc4_sel, aluy_z5_sel, md4_z4_sel, md4_pc4_sel,
			md4_z5_sel, rf_fwd_rs1, rf_fwd_rs2, rf_fwd_rd, mem_fwd_st})
	);

endmodule

// File: source/ir_pipe.sv
`timescale 1ns/100ps

`include "pipe_cfg.svh"

module ir_pipe (
	input  logic              clk,
	input  logic              arst_n,
	input  pipe_pkg::instr_t  instr_in,
	stage_if.pipe             stg
);
	import pipe_pkg::*;

	instr_t ir2_q;
	instr_t ir3_q;
	instr_t ir4_q;
	instr_t ir5_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ir2_q <= `PIPE_NOP_WORD;
			ir3_q <= `PIPE_NOP_WORD;
			ir4_q <= `PIPE_NOP_WORD;
			ir5_q <= `PIPE_NOP_WORD;
		end else begin
			// Write-back stage always advances
			ir5_q <= ir4_q;
			if (stg.pause3) begin
				// Bubble into memory stage, front holds
				ir4_q <= `PIPE_NOP_WORD;
			end else if (stg.pause2) begin
				// Bubble into execute, decode holds
				ir4_q <= ir3_q;
				ir3_q <= `PIPE_NOP_WORD;
			end else begin
				ir4_q <= ir3_q;
				ir3_q <= ir2_q;
				if (stg.nop2) begin
					ir2_q <= `PIPE_NOP_WORD;
				end else begin
					ir2_q <= instr_in;
				end
			end
		end
	end

	assign stg.ir2 = ir2_q;
	assign stg.ir3 = ir3_q;
	assign stg.ir4 = ir4_q;
	assign stg.ir5 = ir5_q;

	// Decode word must survive a stall from the hazard unit
	a_ir2_hold: assert property (
		@(posedge clk) disable iff (!arst_n) stg.pause2 |=> $stable(ir2_q)
	);

endmodule

// File: source/pipe_ctrl.sv
`timescale 1ns/100ps

module pipe_ctrl (
	input  logic              clk,
	input  logic              arst_n,
	input  pipe_pkg::instr_t  instr_in,
	input  logic              cond2,
	input  logic              cond3,
	input  logic              cond4,
	output logic              fetch_stall,
	output pipe_pkg::instr_t  ir2,
	output pipe_pkg::instr_t  ir3,
	output pipe_pkg::instr_t  ir4,
	output pipe_pkg::instr_t  ir5,
	output logic              alux_z4_sel,
	output logic              alux_pc4_sel,
	output logic              alux_z5_sel,
	output logic              aluy_z4_sel,
	output logic              aluy_pc4_sel,
	output logic              aluy_z5_sel,
	output logic              md4_z4_sel,
	output logic              md4_pc4_sel,
	output logic              md4_z5_sel,
	output logic              rf_fwd_rs1,
	output logic              rf_fwd_rs2,
	output logic              rf_fwd_rd,
	output logic              mem_fwd_st
);

	stage_if stg (
		.clk    (clk),
		.arst_n (arst_n)
	);

	ir_pipe u_ir_pipe (
		.clk      (clk),
		.arst_n   (arst_n),
		.instr_in (instr_in),
		.stg      (stg.pipe)
	);

	hazard u_hazard (
		.cond2        (cond2),
		.cond3        (cond3),
		.cond4        (cond4),
		.stg          (stg.hz),
		.fetch_stall  (fetch_stall),
		.alux_z4_sel  (alux_z4_sel),
		.alux_pc4_sel (alux_pc4_sel),
		.alux_z5_sel  (alux_z5_sel),
		.aluy_z4_sel  (aluy_z4_sel),
		.aluy_pc4_sel (aluy_pc4_sel),
		.aluy_z5_sel  (aluy_z5_sel),
		.md4_z4_sel   (md4_z4_sel),
		.md4_pc4_sel  (md4_pc4_sel),
		.md4_z5_sel   (md4_z5_sel),
		.rf_fwd_rs1   (rf_fwd_rs1),
		.rf_fwd_rs2   (rf_fwd_rs2),
		.rf_fwd_rd    (rf_fwd_rd),
		.mem_fwd_st   (mem_fwd_st)
	);

	// Stage words out to the datapath
	assign ir2 = stg.ir2;
	assign ir3 = stg.ir3;
	assign ir4 = stg.ir4;
	assign ir5 = stg.ir5;

endmodule

// File: tb/hazard_model.svh
// Reference model of the stage registers and the hazard rules,
// included inside the testbench module

// Mirrored stage words
instr_t m_ir2, m_ir3, m_ir4, m_ir5;

// Expected pipe controls and selects
logic e_pause2, e_pause3, e_nop2;
logic e_alux_z4, e_alux_pc4, e_alux_z5;
logic e_aluy_z4, e_aluy_pc4, e_aluy_z5;
logic e_md_z4, e_md_pc4, e_md_z5;
logic e_fwd_rs1, e_fwd_rs2, e_fwd_rd, e_mem_st;

function automatic logic is_op(instr_t w, opcode_t o);
	return w[`PIPE_OP_HI:`PIPE_OP_LO] == o;
endfunction

// add through cmp
function automatic logic is_alu(instr_t w);
	return w[`PIPE_OP_HI:`PIPE_OP_LO] inside {[5'd1:5'd7]};
endfunction

// cmp writes no register
function automatic logic is_alu_wr(instr_t w);
	return w[`PIPE_OP_HI:`PIPE_OP_LO] inside {[5'd1:5'd6]};
endfunction

function automatic logic is_cc_wr(instr_t w);
	return is_op(w, op_add) | is_op(w, op_sub) | is_op(w, op_cmp);
endfunction

function automatic logic is_load(instr_t w);
	return is_op(w, op_ld) | is_op(w, op_ldx) | is_op(w, op_ldi);
endfunction

function automatic logic [4:0] rd_of(instr_t w);
	return w[`PIPE_RD_HI:`PIPE_RD_LO];
endfunction

function automatic logic [4:0] rs1_of(instr_t w);
	return w[`PIPE_RS1_HI:`PIPE_RS1_LO];
endfunction

function automatic logic [4:0] rs2_of(instr_t w);
	return w[`PIPE_RS2_HI:`PIPE_RS2_LO];
endfunction

task automatic reset_model();
	m_ir2 = `PIPE_NOP_WORD;
	m_ir3 = `PIPE_NOP_WORD;
	m_ir4 = `PIPE_NOP_WORD;
	m_ir5 = `PIPE_NOP_WORD;
endtask

// Evaluates every rule from the mirrored words and the condition inputs
task automatic eval_rules();
	logic wb4, jl4, wb5, use1, use1p, use2, st3, corner;
	wb4 = is_alu_wr(m_ir4) | is_op(m_ir4, op_ldi);
	jl4 = is_op(m_ir4, op_jmp) & m_ir4[`PIPE_IMM_BIT];
	wb5 = is_alu_wr(m_ir5) | is_load(m_ir5) | (is_op(m_ir5, op_jmp) & m_ir5[`PIPE_IMM_BIT]);
	use1 = is_alu(m_ir3) | is_op(m_ir3, op_ldx) | is_op(m_ir3, op_stx) | is_op(m_ir3, op_jmp);
	use1p = is_alu(m_ir3) | is_op(m_ir3, op_ldx) | is_op(m_ir3, op_stx)
		| (is_op(m_ir3, op_jmp) & m_ir3[`PIPE_IMM_BIT]);
	use2 = is_alu(m_ir3) & ~m_ir3[`PIPE_IMM_BIT];
	st3 = is_op(m_ir3, op_st) | is_op(m_ir3, op_stx);
	e_pause3 = (is_op(m_ir4, op_ld) | is_op(m_ir4, op_ldx))
		& (((rd_of(m_ir4) == rs1_of(m_ir3)) & use1p) | (use2 & (rd_of(m_ir4) == rs2_of(m_ir3))));
	corner = is_alu(m_ir2) & is_load(m_ir3) & is_load(m_ir4)
		& (((rd_of(m_ir3) == rs1_of(m_ir2)) & (rd_of(m_ir4) == rs2_of(m_ir2)))
		| ((rd_of(m_ir3) == rs2_of(m_ir2)) & (rd_of(m_ir4) == rs1_of(m_ir2))));
	e_pause2 = e_pause3 | (is_op(m_ir2, op_br) & is_cc_wr(m_ir3)) | corner;
	e_nop2 = is_op(m_ir2, op_jmp) | is_op(m_ir3, op_jmp) | is_op(m_ir4, op_jmp)
		| is_op(m_ir2, op_hlt) | is_op(m_ir3, op_hlt) | is_op(m_ir4, op_hlt)
		| is_op(m_ir5, op_hlt) | (cond2 & ~is_cc_wr(m_ir3))
		| (is_op(m_ir3, op_br) & cond3) | (is_op(m_ir4, op_br) & cond4);
	e_alux_z4  = (rd_of(m_ir4) == rs1_of(m_ir3)) & use1 & wb4;
	e_alux_pc4 = (rd_of(m_ir4) == rs1_of(m_ir3)) & use1 & jl4;
	e_alux_z5  = (rd_of(m_ir5) == rs1_of(m_ir3)) & use1 & wb5;
	e_aluy_z4  = (rd_of(m_ir4) == rs2_of(m_ir3)) & use2 & wb4;
	e_aluy_pc4 = (rd_of(m_ir4) == rs2_of(m_ir3)) & use2 & jl4;
	e_aluy_z5  = (rd_of(m_ir5) == rs2_of(m_ir3)) & use2 & wb5;
	e_md_z4    = st3 & (rd_of(m_ir4) == rd_of(m_ir3)) & wb4;
	e_md_pc4   = st3 & (rd_of(m_ir4) == rd_of(m_ir3)) & jl4;
	e_md_z5    = st3 & (rd_of(m_ir5) == rd_of(m_ir3)) & wb5;
	e_fwd_rs1 = (rd_of(m_ir5) == rs1_of(m_ir2)) & wb5
		& (is_alu(m_ir2) | is_op(m_ir2, op_ldx) | is_op(m_ir2, op_stx));
	e_fwd_rs2 = (rd_of(m_ir5) == rs2_of(m_ir2)) & is_alu(m_ir2) & ~m_ir2[`PIPE_IMM_BIT] & wb5;
	e_fwd_rd  = (rd_of(m_ir5) == rd_of(m_ir2)) & (is_op(m_ir2, op_st) | is_op(m_ir2, op_stx))
		& wb5;
	e_mem_st  = (rd_of(m_ir5) == rd_of(m_ir4)) & (is_op(m_ir5, op_ld) | is_op(m_ir5, op_ldx))
		& (is_op(m_ir4, op_st) | is_op(m_ir4, op_stx));
endtask

// Stage update at a rising edge, pause3 first, then pause2, then nop2
task automatic step_model(instr_t fetched);
	m_ir5 = m_ir4;
	if (e_pause3) begin
		m_ir4 = `PIPE_NOP_WORD;
	end else if (e_pause2) begin
		m_ir4 = m_ir3;
		m_ir3 = `PIPE_NOP_WORD;
	end else begin
		m_ir4 = m_ir3;
		m_ir3 = m_ir2;
		m_ir2 = e_nop2 ? `PIPE_NOP_WORD : fetched;
	end
endtask

// File: tb/pipe_ctrl_tb.sv
`timescale 1ns/100ps

`include "pipe_cfg.svh"

module pipe_ctrl_tb;
	import pipe_pkg::*;

	localparam int clk_period = 4;
	localparam int rst_cycles = 10;
	localparam int n_cycles   = 3000;
	localparam int rand_seed  = 92300;
	localparam int timeout_ns = n_cycles * clk_period * 2 + rst_cycles * clk_period;

	logic   clk;
	logic   arst_n;
	instr_t instr_in;
	logic   cond2, cond3, cond4;
	logic   fetch_stall;
	instr_t ir2, ir3, ir4, ir5;
	logic   alux_z4_sel, alux_pc4_sel, alux_z5_sel;
	logic   aluy_z4_sel, aluy_pc4_sel, aluy_z5_sel;
	logic   md4_z4_sel, md4_pc4_sel, md4_z5_sel;
	logic   rf_fwd_rs1, rf_fwd_rs2, rf_fwd_rd, mem_fwd_st;

	int n_pause3;
	int n_nop2;

	`include "hazard_model.svh"

	pipe_ctrl pipe_ctrl_i (.*);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Hazard-heavy words, registers limited to r0..r3
	function automatic instr_t random_word();
		instr_t w;
		int unsigned pick;
		w = instr_t'($urandom);
		pick = $urandom_range(99, 0);
		if (pick < 2) begin
			w[`PIPE_OP_HI:`PIPE_OP_LO] = 5'd15;
		end else if (pick < 5) begin
			// Undefined opcode
			w[`PIPE_OP_HI:`PIPE_OP_LO] = 5'($urandom_range(31, 16));
		end else begin
			w[`PIPE_OP_HI:`PIPE_OP_LO] = 5'($urandom_range(14, 0));
		end
		w[`PIPE_RD_HI:`PIPE_RD_LO]   = 5'($urandom_range(3, 0));
		w[`PIPE_RS1_HI:`PIPE_RS1_LO] = 5'($urandom_range(3, 0));
		w[`PIPE_RS2_HI:`PIPE_RS2_LO] = 5'($urandom_range(3, 0));
		return w;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("error %s expected %h actual %h", name, expected, actual);
			$display("sim failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_outputs(input string phase);
		compare_value({phase, " ir2"}, m_ir2, ir2);
		compare_value({phase, " ir3"}, m_ir3, ir3);
		compare_value({phase, " ir4"}, m_ir4, ir4);
		compare_value({phase, " ir5"}, m_ir5, ir5);
		compare_value({phase, " fetch_stall"}, e_pause2, fetch_stall);
		compare_value({phase, " alux_z4_sel"}, e_alux_z4, alux_z4_sel);
		compare_value({phase, " alux_pc4_sel"}, e_alux_pc4, alux_pc4_sel);
		compare_value({phase, " alux_z5_sel"}, e_alux_z5, alux_z5_sel);
		compare_value({phase, " aluy_z4_sel"}, e_aluy_z4, aluy_z4_sel);
		compare_value({phase, " aluy_pc4_sel"}, e_aluy_pc4, aluy_pc4_sel);
		compare_value({phase, " aluy_z5_sel"}, e_aluy_z5, aluy_z5_sel);
		compare_value({phase, " md4_z4_sel"}, e_md_z4, md4_z4_sel);
		compare_value({phase, " md4_pc4_sel"}, e_md_pc4, md4_pc4_sel);
		compare_value({phase, " md4_z5_sel"}, e_md_z5, md4_z5_sel);
		compare_value({phase, " rf_fwd_rs1"}, e_fwd_rs1, rf_fwd_rs1);
		compare_value({phase, " rf_fwd_rs2"}, e_fwd_rs2, rf_fwd_rs2);
		compare_value({phase, " rf_fwd_rd"}, e_fwd_rd, rf_fwd_rd);
		compare_value({phase, " mem_fwd_st"}, e_mem_st, mem_fwd_st);
	endtask

	initial begin
		arst_n   = 1'b0;
		instr_in = `PIPE_NOP_WORD;
		cond2    = 1'b0;
		cond3    = 1'b0;
		cond4    = 1'b0;
		n_pause3 = 0;
		n_nop2   = 0;
		void'($urandom(rand_seed));
		reset_model();
		repeat (rst_cycles) @(negedge clk);
		arst_n = 1'b1;
		#1;
		eval_rules();
		check_outputs("reset");
		for (int cycle = 0; cycle < n_cycles; cycle++) begin
			@(posedge clk);
			step_model(instr_in);
			@(negedge clk);
			eval_rules();
			// Fetch side keeps its word while stalled
			if (!e_pause2) begin
				instr_in = random_word();
			end
			cond2 = 1'($urandom_range(1, 0));
			cond3 = 1'($urandom_range(1, 0));
			cond4 = 1'($urandom_range(1, 0));
			eval_rules();
			#1;
			if (e_pause3) n_pause3++;
			if (e_nop2) n_nop2++;
			check_outputs("random");
		end
		$display("load-use stalls %0d, squash cycles %0d", n_pause3, n_nop2);
		if (n_pause3 == 0 || n_nop2 == 0) begin
			$display("random stimulus never produced a load-use stall or a squash");
			$display("sim failed");
			$fatal(1, "stimulus too weak");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

	initial begin
		#(timeout_ns);
		$display("watchdog expired before the random run finished");
		$display("sim failed");
		$fatal(1, "timeout");
	end

endmodule

// File: verilog.f
+incdir+source
+incdir+tb
source/pipe_pkg.sv
source/stage_if.sv
source/opdec.sv
source/hazard.sv
source/ir_pipe.sv
source/pipe_ctrl.sv
tb/pipe_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the pipe_ctrl testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module pipe_ctrl_tb -f verilog.f \
	-o pipe_ctrl_sim && ./obj_dir/pipe_ctrl_sim > sim.log 2>&1
cat sim.log
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
exit 0
